/* rtl/byte_src_if.sv */
`include "upload_macros.svh"

interface byte_src_if;
   logic                   req;
   logic             [7:0] data;
   logic                   valid;
   logic [`UPL_DDR_AW-1:0] addr;         // Next unread byte

   modport client (output req, input data, valid, addr);
   modport server (input req, output data, valid, addr);
endinterface

/* rtl/ddr_reader.sv */
`include "upload_macros.svh"

module ddr_reader (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   restart,
   byte_src_if.server             cfg,
   byte_src_if.server             fill,
   output logic [`UPL_DDR_AW-1:0] ddr3_addr,
   output logic                   ddr3_rd,
   input  logic             [7:0] ddr3_dout,
   input  logic                   ddr3_ready
);
   logic       waiting;                  // Read accepted, data not yet sampled
   logic       owner_fill;
   logic [7:0] data_q;

   assign cfg.addr  = ddr3_addr;
   assign fill.addr = ddr3_addr;
   assign cfg.data  = data_q;
   assign fill.data = data_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ddr3_rd    <= 1'b0;
         ddr3_addr  <= '0;
         waiting    <= 1'b0;
         owner_fill <= 1'b0;
         cfg.valid  <= 1'b0;
         fill.valid <= 1'b0;
      end else begin
         cfg.valid  <= 1'b0;
         fill.valid <= 1'b0;
         if (restart) ddr3_addr <= '0;
         if (cfg.req | fill.req) begin
            ddr3_rd    <= 1'b1;
            owner_fill <= fill.req;
         end
         if (ddr3_rd & ddr3_ready) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
            waiting   <= 1'b1;
         end
         if (waiting & ddr3_ready) begin
            waiting    <= 1'b0;
            cfg.valid  <= ~owner_fill;
            fill.valid <= owner_fill;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (waiting & ddr3_ready) data_q <= ddr3_dout;
   end
endmodule

/* rtl/fill_cmd_if.sv */
`include "upload_macros.svh"

interface fill_cmd_if
   import upload_pkg::*;
();
   logic                    start;
   logic [`UPL_RAM_AW-1:0]  ram_base;
   logic [`UPL_SIZE_W-1:0]  size;        // Bytes to write
   fill_pat_t               pattern;
   logic                    done;

   modport master (output start, ram_base, size, pattern, input done);
   modport filler (input start, ram_base, size, pattern, output done);
endinterface

/* rtl/memory_upload.sv */
`include "upload_macros.svh"

module memory_upload import upload_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   load,
   input  logic [`UPL_DDR_AW-1:0] image_size,
   output logic                   busy,
   output logic [`UPL_DDR_AW-1:0] ddr3_addr,
   output logic                   ddr3_rd,
   input  logic             [7:0] ddr3_dout,
   input  logic                   ddr3_ready,
   output logic [`UPL_RAM_AW-1:0] ram_addr,
   output logic             [7:0] ram_din,
   output logic                   ram_ce,
   input  logic                   sdram_ready,
   input  logic             [5:0] map_rd_index,
   output map_entry_t             map_rd_entry,
   output msx_typ_t               msx_typ,
   output logic             [3:0] slot_expander_en,
   output logic                   use_fdc,
   output logic             [7:0] ram_size
);
   logic       restart;
   logic       map_clear;
   logic       map_clear_done;
   logic       map_store;
   logic [3:0] slot_sub;
   logic [7:0] mode;
   logic [7:0] param;
   mapper_t    mapper;
   device_t    device;
   logic [3:0] ref_ram;
   logic       used;

   byte_src_if cfg_src ();
   byte_src_if fill_src ();
   fill_cmd_if fill_cmd ();

   ddr_reader ddr_reader_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .restart    (restart),
      .cfg        (cfg_src.server),
      .fill       (fill_src.server),
      .ddr3_addr  (ddr3_addr),
      .ddr3_rd    (ddr3_rd),
      .ddr3_dout  (ddr3_dout),
      .ddr3_ready (ddr3_ready)
   );

   ram_filler ram_filler_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .cmd         (fill_cmd.filler),
      .src         (fill_src.client),
      .ram_addr    (ram_addr),
      .ram_din     (ram_din),
      .ram_ce      (ram_ce),
      .sdram_ready (sdram_ready)
   );

   slot_map slot_map_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .clear      (map_clear),
      .clear_done (map_clear_done),
      .store      (map_store),
      .slot_sub   (slot_sub),
      .mode       (mode),
      .param      (param),
      .mapper     (mapper),
      .device     (device),
      .ref_ram    (ref_ram),
      .used       (used),
      .rd_index   (map_rd_index),
      .rd_entry   (map_rd_entry)
   );

   upload_sequencer upload_sequencer_i (
      .clk              (clk),
      .arst_n           (arst_n),
      .load             (load),
      .image_size       (image_size),
      .busy             (busy),
      .restart          (restart),
      .src              (cfg_src.client),
      .fill             (fill_cmd.master),
      .map_clear        (map_clear),
      .map_clear_done   (map_clear_done),
      .map_store        (map_store),
      .slot_sub         (slot_sub),
      .mode             (mode),
      .param            (param),
      .mapper           (mapper),
      .device           (device),
      .ref_ram          (ref_ram),
      .used             (used),
      .msx_typ          (msx_typ),
      .slot_expander_en (slot_expander_en),
      .use_fdc          (use_fdc),
      .ram_size         (ram_size)
   );
endmodule

/* rtl/ram_filler.sv */
`include "upload_macros.svh"

module ram_filler import upload_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   fill_cmd_if.filler             cmd,
   byte_src_if.client             src,
   output logic [`UPL_RAM_AW-1:0] ram_addr,
   output logic             [7:0] ram_din,
   output logic                   ram_ce,
   input  logic                   sdram_ready
);
   typedef enum logic [1:0] {F_IDLE, F_FETCH, F_WRITE} fill_st_t;

   fill_st_t               st;
   fill_pat_t              pat;
   logic [`UPL_SIZE_W-1:0] cnt;
   logic             [7:0] base_lo;
   logic             [7:0] ofs_lo;
   logic             [7:0] pat_byte;
   logic                   wr_go;

   assign ofs_lo = ram_addr[7:0] - base_lo;    // Low bits of offset in region
   assign wr_go  = (st == F_WRITE) & sdram_ready & ~ram_ce;

   always_comb begin
      case (pat)
         PAT_00:   pat_byte = 8'h00;
         PAT_BIT7: pat_byte = ofs_lo[7] ? 8'hFF : 8'h00;
         default:  pat_byte = 8'hFF;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         st       <= F_IDLE;
         pat      <= PAT_COPY;
         cnt      <= '0;
         ram_addr <= '0;
         ram_ce   <= 1'b0;
         src.req  <= 1'b0;
         cmd.done <= 1'b0;
      end else begin
         ram_ce   <= 1'b0;
         src.req  <= 1'b0;
         cmd.done <= 1'b0;
         if (ram_ce) begin                   // Bookkeeping after each write
            ram_addr <= ram_addr + 1'b1;
            cnt      <= cnt - 1'b1;
            if (cnt == `UPL_SIZE_W'(1)) begin
               st       <= F_IDLE;
               cmd.done <= 1'b1;
            end else if (pat == PAT_COPY) begin
               src.req <= 1'b1;
               st      <= F_FETCH;
            end
         end
         case (st)
            F_IDLE: begin
               if (cmd.start) begin
                  pat      <= cmd.pattern;
                  cnt      <= cmd.size;
                  ram_addr <= cmd.ram_base;
                  if (cmd.size == '0) begin
                     cmd.done <= 1'b1;
                  end else if (cmd.pattern == PAT_COPY) begin
                     src.req <= 1'b1;
                     st      <= F_FETCH;
                  end else begin
                     st <= F_WRITE;
                  end
               end
            end
            F_FETCH: if (src.valid) st <= F_WRITE;
            F_WRITE: if (wr_go) ram_ce <= 1'b1;
            default: st <= F_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (st == F_IDLE && cmd.start) base_lo <= cmd.ram_base[7:0];
      if (st == F_FETCH && src.valid) ram_din <= src.data;
      else if (wr_go && pat != PAT_COPY) ram_din <= pat_byte;
   end
endmodule

/* rtl/slot_map.sv */
`include "upload_macros.svh"

module slot_map import upload_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       clear,
   output logic       clear_done,
   input  logic       store,
   input  logic [3:0] slot_sub,
   input  logic [7:0] mode,
   input  logic [7:0] param,
   input  mapper_t    mapper,
   input  device_t    device,
   input  logic [3:0] ref_ram,
   input  logic       used,
   input  logic [5:0] rd_index,
   output map_entry_t rd_entry
);
   map_entry_t map_q [`UPL_MAP_ENTRIES];
   logic       clr_act;
   logic [5:0] clr_idx;

   // New value of one block from its 2-bit mode m and parameter p
   function automatic map_entry_t block_entry(input logic [1:0] m, input logic [1:0] p);
      map_entry_t e;
      e = map_q[{slot_sub, p}];              // Mirror of block p
      case (m)
         2'd2:    e = '{mapper, device, ref_ram, p, used};
         2'd3:    e = '{MAPPER_UNUSED, device, ref_ram, p, used};
         default: ;
      endcase
      return e;
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         clr_act    <= 1'b0;
         clr_idx    <= '0;
         clear_done <= 1'b0;
      end else begin
         clear_done <= 1'b0;
         if (clear) begin
            clr_act <= 1'b1;
            clr_idx <= '0;
         end else if (clr_act) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == 6'(`UPL_MAP_ENTRIES - 1)) begin
               clr_act    <= 1'b0;
               clear_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clr_act) begin
         map_q[clr_idx] <= '{MAPPER_UNUSED, DEVICE_NONE, 4'd0, 2'd0, 1'b0};
      end else if (store) begin
         for (int b = 0; b < 4; b++) begin
            if (mode[2*b +: 2] != 2'd0)
               map_q[{slot_sub, 2'(b)}] <= block_entry(mode[2*b +: 2], param[2*b +: 2]);
         end
      end
      rd_entry <= map_q[rd_index];
   end
endmodule

/* rtl/upload_macros.svh */
`ifndef UPLOAD_MACROS_SVH
`define UPLOAD_MACROS_SVH

// Record layout in the DDR3 image
`define UPL_REC_LEN 16
`define UPL_SIG0 "M"
`define UPL_SIG1 "S"
`define UPL_SIG2 "X"

// Address and count widths
`define UPL_DDR_AW 28
`define UPL_RAM_AW 27
`define UPL_SIZE_W 25

// One size unit of a record is 16 KB
`define UPL_BLK_SHIFT 14

// 4 slots x 4 subslots x 4 blocks
`define UPL_MAP_ENTRIES 64

`endif

/* rtl/upload_pkg.sv */
package upload_pkg;

   typedef enum logic [3:0] {
      CONF_SLOT_INTERNAL = 4'd0,
      CONF_CONFIG        = 4'd1
   } conf_kind_t;

   typedef enum logic [7:0] {
      MAPPER_UNUSED = 8'd0
   } mapper_t;

   typedef enum logic [7:0] {
      DEVICE_NONE = 8'd0,
      DEVICE_FDC  = 8'd1
   } device_t;

   typedef enum logic [7:0] {
      ROM_NONE = 8'd0,
      ROM_ROM  = 8'd1,
      ROM_RAM  = 8'd2
   } data_id_t;

   // Record byte 4 is both the device code and the data source
   typedef union packed {
      device_t  device;
      data_id_t data_id;
   } mem_kind_u;

   typedef enum logic [2:0] {
      PAT_COPY = 3'd0,
      PAT_FF   = 3'd1,
      PAT_00   = 3'd2,
      PAT_BIT7 = 3'd5
   } fill_pat_t;

   typedef enum logic [1:0] {
      MSX1   = 2'd0,
      MSX2   = 2'd1,
      MSX2P  = 2'd2,
      MSX_TR = 2'd3
   } msx_typ_t;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;            // 16 KB page inside the RAM region
      logic       ram_used;
   } map_entry_t;

endpackage

/* rtl/upload_sequencer.sv */
`include "upload_macros.svh"

module upload_sequencer import upload_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   load,
   input  logic [`UPL_DDR_AW-1:0] image_size,
   output logic                   busy,
   output logic                   restart,
   byte_src_if.client             src,
   fill_cmd_if.master             fill,
   output logic                   map_clear,
   input  logic                   map_clear_done,
   output logic                   map_store,
   output logic             [3:0] slot_sub,
   output logic             [7:0] mode,
   output logic             [7:0] param,
   output mapper_t                mapper,
   output device_t                device,
   output logic             [3:0] ref_ram,
   output logic                   used,
   output msx_typ_t               msx_typ,
   output logic             [3:0] slot_expander_en,
   output logic                   use_fdc,
   output logic             [7:0] ram_size
);
   typedef enum logic [2:0] {S_IDLE, S_CLEAN, S_HEAD, S_READ, S_CHECK, S_FILL, S_STORE} seq_st_t;

   seq_st_t                state;
   logic             [7:0] conf [`UPL_REC_LEN];
   logic             [3:0] byte_idx;
   logic             [3:0] ref_cnt;
   logic                   filled;
   logic [`UPL_RAM_AW-1:0] ram_base;
   logic [`UPL_SIZE_W-1:0] rec_size;
   mem_kind_u              kind;
   logic                   has_data;
   logic                   do_fill;

   assign kind     = conf[4];
   assign rec_size = {conf[5][2:0], conf[6], {`UPL_BLK_SHIFT{1'b0}}};
   assign has_data = (kind.data_id == ROM_ROM) | (kind.data_id == ROM_RAM);
   assign do_fill  = has_data & (rec_size != '0);

   assign busy      = (state != S_IDLE);
   assign map_store = (state == S_STORE);
   assign slot_sub  = conf[3][3:0];
   assign mode      = conf[9];
   assign param     = conf[10];
   assign mapper    = mapper_t'(conf[8]);
   assign device    = kind.device;
   assign ref_ram   = has_data ? ref_cnt : 4'd0;
   assign used      = has_data;

   assign fill.ram_base = ram_base;
   assign fill.size     = rec_size;
   assign fill.pattern  = (kind.data_id == ROM_ROM) ? PAT_COPY : fill_pat_t'(conf[11][2:0]);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state            <= S_IDLE;
         byte_idx         <= '0;
         ref_cnt          <= '0;
         filled           <= 1'b0;
         ram_base         <= '0;
         restart          <= 1'b0;
         map_clear        <= 1'b0;
         src.req          <= 1'b0;
         fill.start       <= 1'b0;
         msx_typ          <= MSX1;
         slot_expander_en <= '0;
         use_fdc          <= 1'b0;
         ram_size         <= '0;
      end else begin
         restart    <= 1'b0;
         map_clear  <= 1'b0;
         src.req    <= 1'b0;
         fill.start <= 1'b0;
         if (load) begin
            state            <= S_CLEAN;
            restart          <= 1'b1;
            map_clear        <= 1'b1;
            ref_cnt          <= '0;
            ram_base         <= '0;
            msx_typ          <= MSX1;
            slot_expander_en <= '0;
            use_fdc          <= 1'b0;
            ram_size         <= '0;
         end else begin
            case (state)
               S_CLEAN: if (map_clear_done) state <= S_HEAD;
               S_HEAD: begin
                  if (src.addr >= image_size) begin
                     state <= S_IDLE;           // Image walked to its end
                  end else begin
                     src.req  <= 1'b1;
                     byte_idx <= '0;
                     state    <= S_READ;
                  end
               end
               S_READ: begin
                  if (src.valid) begin
                     byte_idx <= byte_idx + 1'b1;
                     if (byte_idx == 4'(`UPL_REC_LEN - 1)) state <= S_CHECK;
                     else src.req <= 1'b1;
                  end
               end
               S_CHECK: begin
                  state <= S_HEAD;
                  if ({conf[0], conf[1], conf[2]} == {`UPL_SIG0, `UPL_SIG1, `UPL_SIG2}) begin
                     case (conf_kind_t'(conf[3][7:4]))
                        CONF_CONFIG: begin
                           msx_typ          <= msx_typ_t'(conf[4][5:4]);
                           slot_expander_en <= conf[4][3:0];
                        end
                        CONF_SLOT_INTERNAL: begin
                           state  <= S_STORE;
                           filled <= do_fill;
                           if (kind.device == DEVICE_FDC) use_fdc <= 1'b1;
                           if (kind.data_id == ROM_RAM && ram_size < conf[6]) ram_size <= conf[6];
                           if (do_fill) begin
                              fill.start <= 1'b1;
                              state      <= S_FILL;
                           end
                        end
                        default: ;
                     endcase
                  end
               end
               S_FILL: begin
                  if (fill.done) begin
                     ram_base <= ram_base + {{(`UPL_RAM_AW - `UPL_SIZE_W){1'b0}}, rec_size};
                     state    <= S_STORE;
                  end
               end
               S_STORE: begin
                  ref_cnt <= ref_cnt + 4'(filled);  // Next region gets the next index
                  state   <= S_HEAD;
               end
               default: state <= S_IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_READ && src.valid) conf[byte_idx] <= src.data;
   end
endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert -j 0 -f sim.f \
      --top-module tb_memory_upload -Mdir obj_dir; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vtb_memory_upload > "$log" 2>&1; then
   cat "$log"
   echo "Simulation exited with an error"
   exit 1
fi
cat "$log"

if grep -qx "TESTBENCH PASSED" "$log"; then
   exit 0
fi
exit 1

/* sim.f */
+incdir+rtl
rtl/upload_pkg.sv
rtl/byte_src_if.sv
rtl/fill_cmd_if.sv
rtl/ddr_reader.sv
rtl/ram_filler.sv
rtl/slot_map.sv
rtl/upload_sequencer.sv
rtl/memory_upload.sv
tb/mem_models.sv
tb/tb_memory_upload.sv

/* tb/mem_models.sv */
`include "upload_macros.svh"

// DDR3 image whose ready line moves at random
module ddr_image_model (
   input  logic                   clk,
   input  logic [`UPL_DDR_AW-1:0] ddr3_addr,
   input  logic                   ddr3_rd,
   output logic             [7:0] ddr3_dout,
   output logic                   ddr3_ready
);
   logic [7:0] mem [32768];
   integer     seed;
   int         i;

   task automatic write_byte(input int a, input logic [7:0] d);
      mem[a[14:0]] = d;
   endtask

   initial begin
      seed       = 32'hedee64bd;
      ddr3_ready = 1'b0;
      ddr3_dout  = 8'h00;
      for (i = 0; i < 32768; i++) begin
         mem[i[14:0]] = i[7:0] ^ {1'b0, i[14:8]};
      end
      forever begin
         @(posedge clk);
         if (ddr3_rd && ddr3_ready) ddr3_dout <= mem[ddr3_addr[14:0]];  // Byte of accepted read
         ddr3_ready <= ($random(seed) & 3) != 0;
      end
   end
endmodule

// Captures main RAM writes in the low 64 KB
module ram_capture (
   input  logic                   clk,
   input  logic [`UPL_RAM_AW-1:0] ram_addr,
   input  logic             [7:0] ram_din,
   input  logic                   ram_ce
);
   logic [7:0] mem     [65536];
   logic       written [65536];
   int         wr_count;
   int         stray_count;                 // Writes above 64 KB
   int         i;

   initial begin
      wr_count    = 0;
      stray_count = 0;
      for (i = 0; i < 65536; i++) begin
         written[i[15:0]] = 1'b0;
      end
      forever begin
         @(posedge clk);
         if (ram_ce) begin
            wr_count <= wr_count + 1;
            if (ram_addr[`UPL_RAM_AW-1:16] != '0) begin
               stray_count <= stray_count + 1;
            end else begin
               mem[ram_addr[15:0]]     <= ram_din;
               written[ram_addr[15:0]] <= 1'b1;
            end
         end
      end
   end
endmodule

/* tb/tb_memory_upload.sv */
`include "upload_macros.svh"

module tb_memory_upload import upload_pkg::*; ();
   logic                   clk;
   logic                   arst_n;
   logic                   load;
   logic [`UPL_DDR_AW-1:0] image_size;
   logic                   busy;
   logic [`UPL_DDR_AW-1:0] ddr3_addr;
   logic                   ddr3_rd;
   logic             [7:0] ddr3_dout;
   logic                   ddr3_ready;
   logic [`UPL_RAM_AW-1:0] ram_addr;
   logic             [7:0] ram_din;
   logic                   ram_ce;
   logic                   sdram_ready;
   logic             [5:0] map_rd_index;
   map_entry_t             map_rd_entry;
   msx_typ_t               msx_typ;
   logic             [3:0] slot_expander_en;
   logic                   use_fdc;
   logic             [7:0] ram_size;

   logic             [2:0] stall_cnt;
   int                     checks_run;
   int                     test_errs;
   int                     tests_run;
   int                     tests_failed;
   bit                     timed_out;
   logic [`UPL_DDR_AW-1:0] addr_at_done;     // DDR3 address when busy fell
   int                     writes_at_done;
   map_entry_t             exp_map [64];

   memory_upload memory_upload_i (.*);

   ddr_image_model ddr_model_i (.clk, .ddr3_addr, .ddr3_rd, .ddr3_dout, .ddr3_ready);

   ram_capture ram_model_i (.clk, .ram_addr, .ram_din, .ram_ce);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // SDRAM stalls one cycle in eight
   initial begin
      sdram_ready = 1'b0;
      stall_cnt   = '0;
      forever begin
         @(posedge clk);
         stall_cnt   <= stall_cnt + 3'd1;
         sdram_ready <= (stall_cnt != 3'd5);
      end
   end

   task automatic check(input bit ok, input string msg);
      checks_run++;
      assert (ok) else begin
         $display("Fail at %0t: %s", $time, msg);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errs == 0) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         $display("Test %0d %s: %0d errors", tests_run, name, test_errs);
         tests_failed++;
      end
      test_errs = 0;
   endtask

   function automatic map_entry_t make_entry(input logic [7:0] m, input logic [7:0] d,
                                             input logic [3:0] r, input logic [1:0] o,
                                             input logic u);
      map_entry_t e;
      e.mapper     = mapper_t'(m);
      e.device     = device_t'(d);
      e.ref_ram    = r;
      e.offset_ram = o;
      e.ram_used   = u;
      return e;
   endfunction

   function automatic logic [7:0] expected_fill(input int ofs, input int pat);
      if (pat == 2) return 8'h00;
      if (pat == 5) return ofs[7] ? 8'hFF : 8'h00;
      return 8'hFF;
   endfunction

   task automatic put_record(input int base, input logic [7:0] kind_slot,
                             input logic [7:0] kind_byte, input logic [7:0] units,
                             input logic [7:0] mapper, input logic [7:0] mode,
                             input logic [7:0] param, input logic [7:0] pat);
      int i;
      ddr_model_i.write_byte(base, `UPL_SIG0);
      ddr_model_i.write_byte(base + 1, `UPL_SIG1);
      ddr_model_i.write_byte(base + 2, `UPL_SIG2);
      ddr_model_i.write_byte(base + 3, kind_slot);
      ddr_model_i.write_byte(base + 4, kind_byte);
      ddr_model_i.write_byte(base + 5, 8'h00);
      ddr_model_i.write_byte(base + 6, units);
      ddr_model_i.write_byte(base + 7, 8'hEE);
      ddr_model_i.write_byte(base + 8, mapper);
      ddr_model_i.write_byte(base + 9, mode);
      ddr_model_i.write_byte(base + 10, param);
      ddr_model_i.write_byte(base + 11, pat);
      for (i = 12; i < 16; i++) begin
         ddr_model_i.write_byte(base + i, 8'hEE);
      end
   endtask

   task automatic run_load(input logic [`UPL_DDR_AW-1:0] size, input int limit);
      int n;
      @(posedge clk);
      image_size <= size;
      load       <= 1'b1;
      @(posedge clk);
      load <= 1'b0;
      @(negedge clk);
      check(busy === 1'b1, "busy did not rise after load");
      n = 0;
      while (busy !== 1'b0 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (busy !== 1'b0) begin
         $display("Timeout: busy still high %0d cycles after a load", limit);
         timed_out = 1'b1;
      end else begin
         addr_at_done   = ddr3_addr;
         writes_at_done = ram_model_i.wr_count;
      end
   endtask

   task automatic read_entry(input logic [5:0] idx, output map_entry_t e);
      @(posedge clk);
      map_rd_index <= idx;
      @(posedge clk);
      @(negedge clk);                        // One cycle read latency
      e = map_rd_entry;
   endtask

   task automatic expect_cleared_map();
      int i;
      for (i = 0; i < 64; i++) begin
         exp_map[i[5:0]] = '0;
      end
   endtask

   task automatic compare_map();
      map_entry_t e;
      int         i;
      for (i = 0; i < 64; i++) begin
         read_entry(i[5:0], e);
         check(e == exp_map[i[5:0]],
               $sformatf("map entry %0d is %h, expected %h", i, e, exp_map[i[5:0]]));
      end
   endtask

   task automatic check_copy_region(input int base, input int len, input int src);
      int i;
      int bad;
      int first;
      bad   = 0;
      first = -1;
      for (i = 0; i < len; i++) begin
         if (!ram_model_i.written[16'(base + i)] ||
             ram_model_i.mem[16'(base + i)] !== ddr_model_i.mem[15'(src + i)]) begin
            if (bad == 0) first = base + i;
            bad++;
         end
      end
      check(bad == 0, $sformatf("%0d copied bytes wrong, first at RAM %0d", bad, first));
   endtask

   task automatic check_fill_region(input int base, input int len, input int pat);
      int i;
      int bad;
      int first;
      bad   = 0;
      first = -1;
      for (i = 0; i < len; i++) begin
         if (!ram_model_i.written[16'(base + i)] ||
             ram_model_i.mem[16'(base + i)] !== expected_fill(i, pat)) begin
            if (bad == 0) first = base + i;
            bad++;
         end
      end
      check(bad == 0, $sformatf("pattern %0d at %0d has %0d wrong bytes, first at %0d",
                                pat, base, bad, first));
   endtask

   initial begin
      arst_n         = 1'b0;
      load           = 1'b0;
      image_size     = '0;
      map_rd_index   = '0;
      checks_run     = 0;
      test_errs      = 0;
      tests_run      = 0;
      tests_failed   = 0;
      timed_out      = 1'b0;
      addr_at_done   = '0;
      writes_at_done = 0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check(busy === 1'b0 && ram_ce === 1'b0 && ddr3_rd === 1'b0, "outputs high after reset");
      check(ddr3_addr === '0, "ddr3_addr not zero after reset");
      put_record(0, 8'h01, 8'h01, 8'h01, 8'h05, 8'hAA, 8'h00, 8'h05);
      ddr_model_i.write_byte(1, 8'h00);      // Broken signature
      run_load(28'd16, 2000);
      if (!timed_out) begin
         expect_cleared_map();
         compare_map();
         check(ram_model_i.wr_count == 0, "RAM written by a skipped record");
         check(addr_at_done == 28'd16, "busy fell before the end of the image");
         check(use_fdc === 1'b0, "use_fdc set by a skipped record");
         finish_test("reset and skipped record");
         // ROM copy, two fills, config, FDC and a bad record
         put_record(0, 8'h01, 8'h01, 8'h01, 8'h05, 8'h0E, 8'h04, 8'h00);
         put_record(16400, 8'h01, 8'h02, 8'h01, 8'h07, 8'h60, 8'h20, 8'h05);
         put_record(16416, 8'h06, 8'h02, 8'h02, 8'h33, 8'h03, 8'h03, 8'h02);
         put_record(16432, 8'h10, 8'h2A, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
         put_record(16448, 8'h0F, 8'h01, 8'h00, 8'h09, 8'h02, 8'h01, 8'h00);
         put_record(16464, 8'h02, 8'h02, 8'h01, 8'h05, 8'hFF, 8'h00, 8'h01);
         ddr_model_i.write_byte(16466, 8'h5A);
         run_load(28'd16480, 1000000);
      end
      if (!timed_out) begin
         check_copy_region(0, 16384, 16);
         finish_test("rom copy");
         check_fill_region(16384, 16384, 5);
         check_fill_region(32768, 32768, 2);
         check(ram_model_i.wr_count == 65536, "wrong number of RAM writes");
         check(ram_model_i.stray_count == 0, "RAM written above the filled regions");
         finish_test("pattern fills");
         expect_cleared_map();
         exp_map[4]  = make_entry(8'h05, 8'h01, 4'd0, 2'd0, 1'b1);
         exp_map[5]  = make_entry(8'h00, 8'h01, 4'd0, 2'd1, 1'b1);
         exp_map[6]  = make_entry(8'h07, 8'h02, 4'd1, 2'd2, 1'b1);
         exp_map[7]  = exp_map[4];           // Mirror of block 0
         exp_map[24] = make_entry(8'h00, 8'h02, 4'd2, 2'd3, 1'b1);
         exp_map[60] = make_entry(8'h09, 8'h01, 4'd3, 2'd1, 1'b1);
         compare_map();
         finish_test("slot map modes");
         check(msx_typ == MSX2P, $sformatf("msx_typ is %0d", msx_typ));
         check(slot_expander_en == 4'hA, $sformatf("slot_expander_en is %h", slot_expander_en));
         check(use_fdc === 1'b1, "use_fdc not set by an FDC record");
         check(ram_size == 8'd2, $sformatf("ram_size is %0d", ram_size));
         finish_test("machine config");
         check(addr_at_done == 28'd16480, $sformatf("busy fell at address %0d", addr_at_done));
         check(writes_at_done == 65536, "busy fell before all fills were done");
         check(ddr3_rd === 1'b0, "ddr3_rd high after the end of the image");
         ddr_model_i.write_byte(0, 8'h00);
         run_load(28'd16, 2000);
      end
      if (!timed_out) begin
         expect_cleared_map();
         compare_map();
         check(addr_at_done == 28'd16, $sformatf("reload ended at address %0d", addr_at_done));
         check(ram_model_i.wr_count == 65536, "RAM written by the second load");
         check(msx_typ == MSX1 && slot_expander_en == 4'h0, "config not cleared by load");
         check(use_fdc === 1'b0 && ram_size == 8'd0, "use_fdc or ram_size not cleared by load");
         finish_test("end of image and reload");
      end
      $display("Summary: %0d tests, %0d failed, %0d checks", tests_run, tests_failed, checks_run);
      if (tests_failed == 0 && !timed_out) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end
endmodule
